// ==== afu_fabric_config.svh ====
//--------------------------------------------------------------------------
// Build-time sizing of the PF function fabric
// AFU_NUM_PF must equal 2**AFU_PF_W, the round-robin wraps on that width
// Header field positions assume the 64-bit first beat of a packet
//--------------------------------------------------------------------------
`ifndef AFU_FABRIC_CONFIG_SVH
`define AFU_FABRIC_CONFIG_SVH

// Fabric size
`define AFU_NUM_PF     4
`define AFU_DATA_W     64
`define AFU_PF_W       2

// First-beat header layout
`define AFU_FMT_BIT    63
`define AFU_REQ_PF_LSB 56
`define AFU_CPL_PF_LSB 40

// FLR hold time, in clk cycles
`define AFU_FLR_HOLD   16

`endif

// ==== afu_fabric_pkg.sv ====
//--------------------------------------------------------------------------
// Header types of the host stream
// The first beat is decoded either as a request or as a completion
// Both views keep the format bit at the same position
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

package afu_fabric_pkg;

   typedef logic [`AFU_PF_W-1:0] t_pf_num;

   // Request view, format bit is 0
   typedef struct packed {
      logic                                              fmt;
      logic [`AFU_FMT_BIT-`AFU_REQ_PF_LSB-`AFU_PF_W-1:0] rsvd0;
      t_pf_num                                           pf;      // Target PF
      logic [`AFU_REQ_PF_LSB-49:0]                       rsvd1;
      logic [15:0]                                       len;
      logic [31:0]                                       addr;
   } t_req_hdr;

   // Completion view, format bit is 1
   typedef struct packed {
      logic                                               fmt;
      logic [2:0]                                         status;
      logic [`AFU_FMT_BIT-`AFU_CPL_PF_LSB-`AFU_PF_W-16:0] rsvd0;
      logic [11:0]                                        byte_cnt;
      t_pf_num                                            pf;     // Requester PF
      logic [7:0]                                         tag;
      logic [31:0]                                        rsvd1;
   } t_cpl_hdr;

   typedef union packed {
      t_req_hdr req;
      t_cpl_hdr cpl;
   } t_pcie_hdr;

   // Destination PF of a header beat, view picked by the format bit
   function automatic t_pf_num hdr_dest_pf(t_pcie_hdr hdr);
      return hdr.req.fmt ? hdr.cpl.pf : hdr.req.pf;
   endfunction

endpackage

// ==== pf_stream_if.sv ====
//--------------------------------------------------------------------------
// Packet stream between fabric blocks
// A beat moves on a clk edge with tvalid and tready both high
// tvalid, tdata and tlast hold until the beat moves
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

interface pf_stream_if;

   logic [`AFU_DATA_W-1:0] tdata;
   logic                   tlast;
   logic                   tvalid;
   logic                   tready;

   // Producer side
   modport source (output tdata, output tlast, output tvalid, input tready);

   // Consumer side
   modport sink (input tdata, input tlast, input tvalid, output tready);

endinterface

// ==== flr_rst_mgr.sv ====
//--------------------------------------------------------------------------
// Function-level reset manager
// flr_req_valid is a single-cycle pulse, flr_req_pf names the PF
// A PF in reset ignores further requests until its done pulse
// port_rst_n stays low for AFU_FLR_HOLD cycles, then flr_done pulses
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module flr_rst_mgr
   import afu_fabric_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flr_req_valid,
   input  t_pf_num                flr_req_pf,
   output logic [`AFU_NUM_PF-1:0] flr_done,
   output logic [`AFU_NUM_PF-1:0] port_rst_n
);

   localparam int NUM_PF = `AFU_NUM_PF;
   localparam int CNT_W  = $clog2(`AFU_FLR_HOLD);

   logic [NUM_PF-1:0] busy;
   logic [NUM_PF-1:0] start;
   logic [NUM_PF-1:0] expire;
   logic [CNT_W-1:0]  hold_cnt [NUM_PF];

   // Per-PF start and expiry of the hold window
   for (genvar i = 0; i < NUM_PF; i++) begin : g_evt
      assign start[i]  = flr_req_valid & (flr_req_pf == t_pf_num'(i)) & ~busy[i];
      assign expire[i] = busy[i] & (hold_cnt[i] == '0);
   end

   //-----------------------------------------------------------------------
   // Hold counters and port resets
   //-----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy       <= '0;
         flr_done   <= '0;
         port_rst_n <= '0;
         for (int i = 0; i < NUM_PF; i++) begin
            hold_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_PF; i++) begin
            // Done pulses on the cycle the port leaves reset
            flr_done[i] <= expire[i];
            if (start[i]) begin
               busy[i]     <= 1'b1;
               hold_cnt[i] <= CNT_W'(`AFU_FLR_HOLD - 1);
            end else if (expire[i]) begin
               busy[i]     <= 1'b0;
            end else if (busy[i]) begin
               hold_cnt[i] <= hold_cnt[i] - 1'b1;
            end
            // Low while counting, and from the request edge
            port_rst_n[i] <= ~start[i] & (~busy[i] | expire[i]);
         end
      end
   end

endmodule

// ==== stream_skid_stage.sv ====
//--------------------------------------------------------------------------
// One-stage skid pipeline
// Full throughput, with tready to the producer taken from a register
// rst_n is the per-port reset, it empties both registers
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module stream_skid_stage (
   input  logic        clk,
   input  logic        rst_n,
   pf_stream_if.sink   in,
   pf_stream_if.source out
);

   logic                   main_valid;
   logic [`AFU_DATA_W-1:0] main_data;
   logic                   main_last;
   logic                   skid_valid;
   logic [`AFU_DATA_W-1:0] skid_data;
   logic                   skid_last;
   logic                   in_fire;
   logic                   main_load;

   // Ready while the skid register is empty
   assign in.tready = ~skid_valid;
   assign in_fire   = in.tvalid & ~skid_valid;

   // Main register takes a beat when empty or draining
   assign main_load = ~main_valid | out.tready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else if (main_load) begin
         main_valid <= skid_valid | in_fire;
         skid_valid <= 1'b0;
      end else if (in_fire) begin
         // Output stalled, park the incoming beat
         skid_valid <= 1'b1;
      end
   end

   // Payload, skid beat goes first
   always_ff @(posedge clk) begin
      if (main_load) begin
         main_data <= skid_valid ? skid_data : in.tdata;
         main_last <= skid_valid ? skid_last : in.tlast;
      end else if (in_fire) begin
         skid_data <= in.tdata;
         skid_last <= in.tlast;
      end
   end

   assign out.tvalid = main_valid;
   assign out.tdata  = main_data;
   assign out.tlast  = main_last;

endmodule

// ==== pf_rx_demux.sv ====
//--------------------------------------------------------------------------
// Host RX demultiplexer
// Routes each packet by its first beat, one output register shared by all
// Packets for a PF in reset are taken and dropped, to the end of the packet
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module pf_rx_demux
   import afu_fabric_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`AFU_DATA_W-1:0] host_rx_tdata,
   input  logic                   host_rx_tlast,
   input  logic                   host_rx_tvalid,
   output logic                   host_rx_tready,
   input  logic [`AFU_NUM_PF-1:0] port_rst_n,
   pf_stream_if.source            pf_out [`AFU_NUM_PF]
);

   t_pcie_hdr              hdr;
   t_pf_num                hdr_pf;
   t_pf_num                cur_dest;
   t_pf_num                dest_q;
   logic                   in_pkt;
   logic                   drop_q;
   logic                   cur_drop;
   logic                   accept;
   logic                   fwd;
   logic                   out_valid;
   logic                   out_ready;
   logic [`AFU_DATA_W-1:0] out_data;
   logic                   out_last;
   logic [`AFU_NUM_PF-1:0] out_tready;

   // Header decode, used on the first beat only
   assign hdr      = host_rx_tdata;
   assign hdr_pf   = hdr_dest_pf(hdr);
   assign cur_dest = in_pkt ? dest_q : hdr_pf;
   // Drop is sticky, an FLR mid-packet drops the tail too
   assign cur_drop = ~port_rst_n[cur_dest] | (in_pkt & drop_q);

   // dest_q only follows forwarded beats, so it also tags the output register
   assign out_ready      = out_tready[dest_q];
   assign host_rx_tready = cur_drop | ~out_valid | out_ready;
   assign accept         = host_rx_tvalid & host_rx_tready;
   assign fwd            = accept & ~cur_drop;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_pkt    <= 1'b0;
         drop_q    <= 1'b0;
         dest_q    <= '0;
         out_valid <= 1'b0;
      end else begin
         if (accept) begin
            in_pkt <= ~host_rx_tlast;
            drop_q <= cur_drop;
         end
         if (fwd) begin
            dest_q    <= cur_dest;
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fwd) begin
         out_data <= host_rx_tdata;
         out_last <= host_rx_tlast;
      end
   end

   // Fan the output register out to the PF ports
   for (genvar i = 0; i < `AFU_NUM_PF; i++) begin : g_port
      assign pf_out[i].tdata  = out_data;
      assign pf_out[i].tlast  = out_last;
      assign pf_out[i].tvalid = out_valid & (dest_q == t_pf_num'(i));
      assign out_tready[i]    = pf_out[i].tready;
   end

endmodule

// ==== pf_tx_arb.sv ====
//--------------------------------------------------------------------------
// PF TX to host arbiter
// Round-robin per packet, grant held until tlast
// Ports in FLR are not granted, an FLR on the granted port frees the lock
// Output register holds while host_tx_tready is low
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module pf_tx_arb
   import afu_fabric_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`AFU_NUM_PF-1:0] port_rst_n,
   pf_stream_if.sink              pf_in [`AFU_NUM_PF],
   output logic [`AFU_DATA_W-1:0] host_tx_tdata,
   output logic                   host_tx_tlast,
   output logic                   host_tx_tvalid,
   input  logic                   host_tx_tready
);

   localparam int NUM_PF = `AFU_NUM_PF;

   logic [NUM_PF-1:0]      req;
   logic [NUM_PF-1:0]      in_last;
   logic [`AFU_DATA_W-1:0] in_data [NUM_PF];
   t_pf_num                gnt_q;
   t_pf_num                pick;
   t_pf_num                cur_gnt;
   logic                   pick_ok;
   logic                   locked;
   logic                   cur_req;
   logic                   out_free;
   logic                   take;

   for (genvar i = 0; i < NUM_PF; i++) begin : g_port
      assign req[i]          = pf_in[i].tvalid & port_rst_n[i];
      assign in_data[i]      = pf_in[i].tdata;
      assign in_last[i]      = pf_in[i].tlast;
      assign pf_in[i].tready = take & (cur_gnt == t_pf_num'(i));
   end

   //-----------------------------------------------------------------------
   // Round-robin pick, starting after the last grant
   //-----------------------------------------------------------------------
   always_comb begin
      pick    = gnt_q;
      pick_ok = 1'b0;
      // Walk down so the nearest requester after gnt_q wins
      for (int k = NUM_PF; k >= 1; k--) begin
         if (req[t_pf_num'(gnt_q + k)]) begin
            pick    = t_pf_num'(gnt_q + k);
            pick_ok = 1'b1;
         end
      end
   end

   assign cur_gnt  = locked ? gnt_q : pick;
   assign cur_req  = locked ? req[gnt_q] : pick_ok;
   assign out_free = ~host_tx_tvalid | host_tx_tready;
   assign take     = out_free & cur_req;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gnt_q          <= '0;
         locked         <= 1'b0;
         host_tx_tvalid <= 1'b0;
      end else begin
         if (take) begin
            gnt_q  <= cur_gnt;
            locked <= ~in_last[cur_gnt];
         end else if (locked && !port_rst_n[gnt_q]) begin
            locked <= 1'b0;
         end
         if (take) begin
            host_tx_tvalid <= 1'b1;
         end else if (host_tx_tready) begin
            host_tx_tvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         host_tx_tdata <= in_data[cur_gnt];
         host_tx_tlast <= in_last[cur_gnt];
      end
   end

endmodule

// ==== afu_fabric_top.sv ====
//--------------------------------------------------------------------------
// Host-side function fabric, top level
// PF lanes are flattened, lane n belongs to PF n
// All logic runs on clk, port resets come from the FLR manager
// Host RX to fn_rx and fn_tx to host TX each take 2 cycles
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module afu_fabric_top
   import afu_fabric_pkg::*;
(
   input  logic                                     clk,
   input  logic                                     rst_n,

   // Host RX
   input  logic [`AFU_DATA_W-1:0]                   host_rx_tdata,
   input  logic                                     host_rx_tlast,
   input  logic                                     host_rx_tvalid,
   output logic                                     host_rx_tready,

   // Host TX
   output logic [`AFU_DATA_W-1:0]                   host_tx_tdata,
   output logic                                     host_tx_tlast,
   output logic                                     host_tx_tvalid,
   input  logic                                     host_tx_tready,

   // FLR request and response
   input  logic                                     flr_req_valid,
   input  t_pf_num                                  flr_req_pf,
   output logic [`AFU_NUM_PF-1:0]                   flr_done,

   // PF RX lanes
   output logic [`AFU_NUM_PF-1:0][`AFU_DATA_W-1:0]  fn_rx_tdata,
   output logic [`AFU_NUM_PF-1:0]                   fn_rx_tlast,
   output logic [`AFU_NUM_PF-1:0]                   fn_rx_tvalid,
   input  logic [`AFU_NUM_PF-1:0]                   fn_rx_tready,

   // PF TX lanes
   input  logic [`AFU_NUM_PF-1:0][`AFU_DATA_W-1:0]  fn_tx_tdata,
   input  logic [`AFU_NUM_PF-1:0]                   fn_tx_tlast,
   input  logic [`AFU_NUM_PF-1:0]                   fn_tx_tvalid,
   output logic [`AFU_NUM_PF-1:0]                   fn_tx_tready
);

   logic [`AFU_NUM_PF-1:0] port_rst_n;

   // RX: demux to stage to lane, TX: lane to stage to arbiter
   pf_stream_if dmx2stg [`AFU_NUM_PF] ();
   pf_stream_if stg2fn  [`AFU_NUM_PF] ();
   pf_stream_if fn2stg  [`AFU_NUM_PF] ();
   pf_stream_if stg2arb [`AFU_NUM_PF] ();

   flr_rst_mgr i_flr_rst_mgr (
      .clk           (clk),
      .rst_n         (rst_n),
      .flr_req_valid (flr_req_valid),
      .flr_req_pf    (flr_req_pf),
      .flr_done      (flr_done),
      .port_rst_n    (port_rst_n)
   );

   pf_rx_demux i_pf_rx_demux (
      .clk            (clk),
      .rst_n          (rst_n),
      .host_rx_tdata  (host_rx_tdata),
      .host_rx_tlast  (host_rx_tlast),
      .host_rx_tvalid (host_rx_tvalid),
      .host_rx_tready (host_rx_tready),
      .port_rst_n     (port_rst_n),
      .pf_out         (dmx2stg)
   );

   pf_tx_arb i_pf_tx_arb (
      .clk            (clk),
      .rst_n          (rst_n),
      .port_rst_n     (port_rst_n),
      .pf_in          (stg2arb),
      .host_tx_tdata  (host_tx_tdata),
      .host_tx_tlast  (host_tx_tlast),
      .host_tx_tvalid (host_tx_tvalid),
      .host_tx_tready (host_tx_tready)
   );

   //-----------------------------------------------------------------------
   // Per-PF pipelines, held in reset with their port
   //-----------------------------------------------------------------------
   for (genvar i = 0; i < `AFU_NUM_PF; i++) begin : g_pf
      stream_skid_stage i_rx_stage (
         .clk   (clk),
         .rst_n (port_rst_n[i]),
         .in    (dmx2stg[i]),
         .out   (stg2fn[i])
      );

      assign fn_rx_tdata[i]   = stg2fn[i].tdata;
      assign fn_rx_tlast[i]   = stg2fn[i].tlast;
      assign fn_rx_tvalid[i]  = stg2fn[i].tvalid;
      assign stg2fn[i].tready = fn_rx_tready[i];

      assign fn2stg[i].tdata  = fn_tx_tdata[i];
      assign fn2stg[i].tlast  = fn_tx_tlast[i];
      assign fn2stg[i].tvalid = fn_tx_tvalid[i];
      assign fn_tx_tready[i]  = fn2stg[i].tready;

      stream_skid_stage i_tx_stage (
         .clk   (clk),
         .rst_n (port_rst_n[i]),
         .in    (fn2stg[i]),
         .out   (stg2arb[i])
      );
   end

endmodule

// ==== tb_clk_gen.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset
// 40 ns clock, rst_n low for the first 10 cycles, released on a falling edge
//--------------------------------------------------------------------------
module tb_clk_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int PERIOD_NS = 40;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk) rst_n = 1'b1;
   end

endmodule

// ==== afu_fabric_chk.sv ====
//--------------------------------------------------------------------------
// Protocol and timing checks of the PF fabric
// Bound into the top level
// Expects TX beats to carry their source PF in the request PF field
// err_cnt counts every failed assertion
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module afu_fabric_chk (
   input logic                                    clk,
   input logic                                    rst_n,
   input logic [`AFU_NUM_PF-1:0]                  port_rst_n,
   input logic [`AFU_NUM_PF-1:0][`AFU_DATA_W-1:0] fn_rx_tdata,
   input logic [`AFU_NUM_PF-1:0]                  fn_rx_tlast,
   input logic [`AFU_NUM_PF-1:0]                  fn_rx_tvalid,
   input logic [`AFU_NUM_PF-1:0]                  fn_rx_tready,
   input logic [`AFU_DATA_W-1:0]                  host_tx_tdata,
   input logic                                    host_tx_tlast,
   input logic                                    host_tx_tvalid,
   input logic                                    host_tx_tready,
   input logic                                    flr_req_valid,
   input logic [`AFU_PF_W-1:0]                    flr_req_pf,
   input logic [`AFU_NUM_PF-1:0]                  flr_done
);
   timeunit 1ns;
   timeprecision 1ps;

   int                     err_cnt = 0;
   logic [`AFU_NUM_PF-1:0] rx_mid;
   logic                   tx_mid;
   logic [`AFU_PF_W-1:0]   tx_src;

   // Format bit picks the PF field of a header beat
   function automatic logic [`AFU_PF_W-1:0] beat_pf(logic [`AFU_DATA_W-1:0] d);
      return d[`AFU_FMT_BIT] ? d[`AFU_CPL_PF_LSB +: `AFU_PF_W]
                             : d[`AFU_REQ_PF_LSB +: `AFU_PF_W];
   endfunction

   // Track packet boundaries on each lane and on host TX
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_mid <= '0;
         tx_mid <= 1'b0;
         tx_src <= '0;
      end else begin
         for (int n = 0; n < `AFU_NUM_PF; n++) begin
            if (!port_rst_n[n]) begin
               rx_mid[n] <= 1'b0;
            end else if (fn_rx_tvalid[n] && fn_rx_tready[n]) begin
               rx_mid[n] <= ~fn_rx_tlast[n];
            end
         end
         if (host_tx_tvalid && host_tx_tready) begin
            tx_mid <= ~host_tx_tlast;
            if (!tx_mid) begin
               tx_src <= host_tx_tdata[`AFU_REQ_PF_LSB +: `AFU_PF_W];
            end
         end
      end
   end

   //-----------------------------------------------------------------------
   // Per-lane checks
   //-----------------------------------------------------------------------
   for (genvar n = 0; n < `AFU_NUM_PF; n++) begin : g_lane
      a_rx_dest: assert property (@(posedge clk) disable iff (!rst_n)
         fn_rx_tvalid[n] && !rx_mid[n] |-> beat_pf(fn_rx_tdata[n]) == n)
         else begin
            err_cnt++;
            $error("fn_rx lane %0d got a header for another PF", n);
         end

      a_rx_hold: assert property (@(posedge clk) disable iff (!rst_n || !port_rst_n[n])
         fn_rx_tvalid[n] && !fn_rx_tready[n] |=>
         fn_rx_tvalid[n] && $stable(fn_rx_tdata[n]) && $stable(fn_rx_tlast[n]))
         else begin
            err_cnt++;
            $error("fn_rx lane %0d beat changed before transfer", n);
         end

      a_rx_flr: assert property (@(posedge clk) disable iff (!rst_n)
         !port_rst_n[n] |-> !fn_rx_tvalid[n])
         else begin
            err_cnt++;
            $error("fn_rx lane %0d valid while in FLR", n);
         end

      a_flr_done: assert property (@(posedge clk) disable iff (!rst_n)
         flr_req_valid && flr_req_pf == n && port_rst_n[n] |->
         ##(`AFU_FLR_HOLD + 1) flr_done[n])
         else begin
            err_cnt++;
            $error("flr_done %0d not on time", n);
         end

      // Low for the whole hold window, high on the next cycle
      a_flr_hold: assert property (@(posedge clk) disable iff (!rst_n)
         $fell(port_rst_n[n]) |->
         (!port_rst_n[n]) [*`AFU_FLR_HOLD] ##1 port_rst_n[n])
         else begin
            err_cnt++;
            $error("port reset %0d has the wrong length", n);
         end
   end

   // Host TX checks
   a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
      host_tx_tvalid && !host_tx_tready |=>
      host_tx_tvalid && $stable(host_tx_tdata) && $stable(host_tx_tlast))
      else begin
         err_cnt++;
         $error("host_tx beat changed before transfer");
      end

   a_tx_lock: assert property (@(posedge clk) disable iff (!rst_n)
      host_tx_tvalid && tx_mid |-> host_tx_tdata[`AFU_REQ_PF_LSB +: `AFU_PF_W] == tx_src)
      else begin
         err_cnt++;
         $error("host_tx interleaved two packets");
      end

endmodule

bind afu_fabric_top afu_fabric_chk i_chk (
   .clk            (clk),
   .rst_n          (rst_n),
   .port_rst_n     (port_rst_n),
   .fn_rx_tdata    (fn_rx_tdata),
   .fn_rx_tlast    (fn_rx_tlast),
   .fn_rx_tvalid   (fn_rx_tvalid),
   .fn_rx_tready   (fn_rx_tready),
   .host_tx_tdata  (host_tx_tdata),
   .host_tx_tlast  (host_tx_tlast),
   .host_tx_tvalid (host_tx_tvalid),
   .host_tx_tready (host_tx_tready),
   .flr_req_valid  (flr_req_valid),
   .flr_req_pf     (flr_req_pf),
   .flr_done       (flr_done)
);

// ==== afu_fabric_tb.sv ====
//--------------------------------------------------------------------------
// Testbench of the PF fabric
// Counts packets per port, bound assertions check the protocol and timing
// TX beats carry their source lane in the request PF field
//--------------------------------------------------------------------------
`include "afu_fabric_config.svh"

module afu_fabric_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NPF         = `AFU_NUM_PF;
   localparam int NUM_TESTS   = 6;
   localparam int TEST_CYCLES = 600;

   logic                               clk;
   logic                               rst_n;
   logic [`AFU_DATA_W-1:0]             host_rx_tdata;
   logic                               host_rx_tlast;
   logic                               host_rx_tvalid;
   logic                               host_rx_tready;
   logic [`AFU_DATA_W-1:0]             host_tx_tdata;
   logic                               host_tx_tlast;
   logic                               host_tx_tvalid;
   logic                               host_tx_tready;
   logic                               flr_req_valid;
   logic [`AFU_PF_W-1:0]               flr_req_pf;
   logic [NPF-1:0]                     flr_done;
   logic [NPF-1:0][`AFU_DATA_W-1:0]    fn_rx_tdata;
   logic [NPF-1:0]                     fn_rx_tlast;
   logic [NPF-1:0]                     fn_rx_tvalid;
   logic [NPF-1:0]                     fn_rx_tready;
   logic [NPF-1:0][`AFU_DATA_W-1:0]    fn_tx_tdata;
   logic [NPF-1:0]                     fn_tx_tlast;
   logic [NPF-1:0]                     fn_tx_tvalid;
   logic [NPF-1:0]                     fn_tx_tready;

   int seed = 32'hf580ae87;
   bit rand_ready;
   int rx_exp[NPF], rx_got[NPF], tx_exp[NPF], tx_got[NPF], done_exp[NPF], done_got[NPF];
   int pass_cnt, fail_cnt, chk_base;

   tb_clk_gen i_tb_clk_gen (.clk(clk), .rst_n(rst_n));

   afu_fabric_top i_afu_fabric_top (.*);

   // Watchdog, four times the summed test budgets
   initial begin
      #(NUM_TESTS * TEST_CYCLES * 4 * 40);
      $display("Run stopped by the watchdog, traffic did not drain");
      $display("sim failed");
      $finish;
   end

   // Ready patterns, driven on the falling edge
   always @(negedge clk) begin
      if (rand_ready) begin
         host_tx_tready <= $random(seed) & 1;
         fn_rx_tready   <= $random(seed);
      end else begin
         host_tx_tready <= 1'b1;
         fn_rx_tready   <= '1;
      end
   end

   // Packet and done counters, sampled before the edge updates
   always @(posedge clk) begin
      if (rst_n) begin
         for (int n = 0; n < NPF; n++) begin
            if (fn_rx_tvalid[n] && fn_rx_tready[n] && fn_rx_tlast[n]) rx_got[n]++;
            if (flr_done[n]) done_got[n]++;
         end
         if (host_tx_tvalid && host_tx_tready && host_tx_tlast)
            tx_got[host_tx_tdata[`AFU_REQ_PF_LSB +: `AFU_PF_W]]++;
      end
   end

   // One host packet; a completion gets a decoy in the request PF field
   task automatic send_rx_pkt(int pf, bit cpl, int len, bit counted);
      logic [`AFU_DATA_W-1:0] d;
      if (counted) rx_exp[pf]++;
      for (int b = 0; b < len; b++) begin
         d = {$random(seed), $random(seed)};
         if (b == 0) begin
            d[`AFU_FMT_BIT] = cpl;
            d[`AFU_REQ_PF_LSB +: `AFU_PF_W] = cpl ? pf + 1 : pf;
            if (cpl) d[`AFU_CPL_PF_LSB +: `AFU_PF_W] = pf;
         end
         @(negedge clk);
         host_rx_tvalid = 1'b1;
         host_rx_tdata  = d;
         host_rx_tlast  = (b == len - 1);
         do @(posedge clk); while (!host_rx_tready);
      end
      @(negedge clk) host_rx_tvalid = 1'b0;
      repeat ($random(seed) & 3) @(negedge clk);
   endtask

   // One packet from a PF lane
   task automatic send_tx_pkt(int ln, int len);
      tx_exp[ln]++;
      for (int b = 0; b < len; b++) begin
         @(negedge clk);
         fn_tx_tvalid[ln] = 1'b1;
         fn_tx_tdata[ln]  = {$random(seed), $random(seed)};
         fn_tx_tdata[ln][`AFU_REQ_PF_LSB +: `AFU_PF_W] = ln;
         fn_tx_tlast[ln]  = (b == len - 1);
         do @(posedge clk); while (!fn_tx_tready[ln]);
      end
      @(negedge clk) fn_tx_tvalid[ln] = 1'b0;
   endtask

   task automatic tx_burst(int ln, int npkt);
      for (int p = 0; p < npkt; p++) send_tx_pkt(ln, 1 + ($random(seed) & 3));
   endtask

   task automatic rx_burst(bit cpl, int npkt);
      for (int p = 0; p < npkt; p++)
         send_rx_pkt($random(seed) & (NPF - 1), cpl, 1 + ($random(seed) & 3), 1'b1);
   endtask

   task automatic flr_pulse(int pf, bit expect_done);
      if (expect_done) done_exp[pf]++;
      @(negedge clk);
      flr_req_valid = 1'b1;
      flr_req_pf    = pf;
      @(negedge clk) flr_req_valid = 1'b0;
   endtask

   function automatic bit counts_match();
      for (int n = 0; n < NPF; n++)
         if (rx_got[n] != rx_exp[n] || tx_got[n] != tx_exp[n] || done_got[n] != done_exp[n])
            return 1'b0;
      return 1'b1;
   endfunction

   // Wait for traffic to drain, then report the test
   task automatic end_test(string name);
      int errs;
      errs = 0;
      for (int c = 0; c < TEST_CYCLES && !counts_match(); c++) @(posedge clk);
      for (int n = 0; n < NPF; n++) begin
         if (rx_got[n] != rx_exp[n]) begin
            $display("Error: %s fn_rx%0d expected %0d actual %0d", name, n, rx_exp[n], rx_got[n]);
            errs++;
         end
         if (tx_got[n] != tx_exp[n]) begin
            $display("Error: %s tx from pf%0d expected %0d actual %0d", name, n, tx_exp[n],
                     tx_got[n]);
            errs++;
         end
         if (done_got[n] != done_exp[n]) begin
            $display("Error: %s flr_done%0d expected %0d actual %0d", name, n, done_exp[n],
                     done_got[n]);
            errs++;
         end
      end
      if (i_afu_fabric_top.i_chk.err_cnt != chk_base) begin
         $display("%s: assertions failed during the test", name);
         errs++;
      end
      chk_base = i_afu_fabric_top.i_chk.err_cnt;
      if (errs == 0) begin
         pass_cnt++;
         $display("PASS %s", name);
      end else begin
         fail_cnt++;
         $display("FAIL %s", name);
      end
   endtask

   initial begin
      host_rx_tdata  = '0;
      host_rx_tlast  = 1'b0;
      host_rx_tvalid = 1'b0;
      host_tx_tready = 1'b1;
      fn_rx_tready   = '1;
      fn_tx_tdata    = '0;
      fn_tx_tlast    = '0;
      fn_tx_tvalid   = '0;
      flr_req_valid  = 1'b0;
      flr_req_pf     = '0;
      rand_ready     = 1'b0;
      wait (rst_n);
      repeat (3) @(posedge clk);

      rx_burst(1'b0, 16);
      end_test("request_routing");

      rx_burst(1'b1, 16);
      end_test("completion_routing");

      rand_ready = 1'b1;
      for (int l = 0; l < NPF; l++) begin
         fork
            automatic int ln = l;
            tx_burst(ln, 4);
         join_none
      end
      rx_burst($random(seed) & 1, 16);
      wait fork;
      end_test("back_pressure");
      rand_ready = 1'b0;

      for (int l = 0; l < NPF; l++) begin
         fork
            automatic int ln = l;
            tx_burst(ln, 6);
         join_none
      end
      wait fork;
      end_test("tx_arbitration");

      // Second request lands while PF1 is still in reset
      flr_pulse(1, 1'b1);
      repeat (3) @(negedge clk);
      flr_pulse(1, 1'b0);
      end_test("flr_timing");

      // Packets to PF0 during its FLR are dropped, others keep flowing
      flr_pulse(0, 1'b1);
      send_rx_pkt(0, 1'b0, 1, 1'b0);
      send_rx_pkt(0, 1'b1, 2, 1'b0);
      for (int p = 0; p < 6; p++) send_rx_pkt(1 + p % 3, p & 1, 2, 1'b1);
      wait (done_got[0] == done_exp[0]);
      tx_burst(0, 2);
      send_rx_pkt(0, 1'b0, 2, 1'b1);
      end_test("flr_discard");

      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== afu_fabric.f ====
+incdir+.
afu_fabric_pkg.sv
pf_stream_if.sv
flr_rst_mgr.sv
stream_skid_stage.sv
pf_rx_demux.sv
pf_tx_arb.sv
afu_fabric_top.sv
tb_clk_gen.sv
afu_fabric_chk.sv
afu_fabric_tb.sv

// ==== Makefile ====
TOP = afu_fabric_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f afu_fabric.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
